//--- bench/clk_gen.sv
module clk_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    // Free-running clock, low for the first half period
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2);
            clk = ~clk;
        end
    end

endmodule

//--- bench/tb_collision_detector.sv
`include "sat_macros.svh"

module tb_collision_detector;
    import fxp_pkg::*;

    localparam int unsigned SEED          = 32'hfeda36c3;
    localparam int          RESET_CYCLES  = 10;
    localparam int          DRAIN_TIMEOUT = 40;
    localparam int          NUM_RANDOM    = 300;
    localparam int          UNIT          = 1 << 25;
    localparam int          POS_SPAN      = 16 * UNIT;
    // Q14 axis components
    localparam axis_t       ONE           = 16384;
    localparam axis_t       DIAG          = 11585;

    logic  clk;
    logic  rst;
    logic  in_valid;
    logic  out_valid;
    logic  is_collision;

    // Index 0 is rectangle a, index 1 is rectangle b
    dim_t  rect_w  [2];
    dim_t  rect_h  [2];
    pos_t  rect_px [2];
    pos_t  rect_py [2];
    axis_t rect_ux [2];
    axis_t rect_uy [2];
    axis_t rect_vx [2];
    axis_t rect_vy [2];

    bit    exp_q  [$];
    string name_q [$];
    bit    exp_head;
    string head_name;
    string cur_test;
    int    queries_sent;
    int    results_seen;

    clk_gen #(.PERIOD(8)) u_clk (.clk(clk));

    collision_detector u_dut (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .width_a      (rect_w[0]),
        .height_a     (rect_h[0]),
        .pos_a_x      (rect_px[0]),
        .pos_a_y      (rect_py[0]),
        .u_a_x        (rect_ux[0]),
        .u_a_y        (rect_uy[0]),
        .v_a_x        (rect_vx[0]),
        .v_a_y        (rect_vy[0]),
        .width_b      (rect_w[1]),
        .height_b     (rect_h[1]),
        .pos_b_x      (rect_px[1]),
        .pos_b_y      (rect_py[1]),
        .u_b_x        (rect_ux[1]),
        .u_b_y        (rect_uy[1]),
        .v_b_x        (rect_vx[1]),
        .v_b_y        (rect_vy[1]),
        .out_valid    (out_valid),
        .is_collision (is_collision)
    );

    // True when the corners of own clear the extent of ref along one of ref's axes
    function automatic bit direction_separates(input int own_i, input int ref_i);
        longint half [2];
        longint lim  [2];
        longint d    [2];
        longint proj [2];
        longint lo   [2];
        longint hi   [2];
        longint sw;
        longint sh;
        bit     sep;
        half[0] = longint'(rect_w[own_i]) >> 1;
        half[1] = longint'(rect_h[own_i]) >> 1;
        lim[0] = (longint'(rect_w[ref_i]) >> 1) <<< `SAT_EXTENT_SHIFT;
        lim[1] = (longint'(rect_h[ref_i]) >> 1) <<< `SAT_EXTENT_SHIFT;
        for (int i = 0; i < `SAT_NUM_CORNERS; i++) begin
            sw = (i >= 2) ? half[0] : -half[0];
            sh = (i % 2 == 1) ? half[1] : -half[1];
            // Corner relative to the reference centre, in Q14 units
            d[0] = sw * rect_ux[own_i] + sh * rect_vx[own_i]
                   + (longint'(rect_px[own_i]) >>> `SAT_POS_SHIFT)
                   - (longint'(rect_px[ref_i]) >>> `SAT_POS_SHIFT);
            d[1] = sw * rect_uy[own_i] + sh * rect_vy[own_i]
                   + (longint'(rect_py[own_i]) >>> `SAT_POS_SHIFT)
                   - (longint'(rect_py[ref_i]) >>> `SAT_POS_SHIFT);
            proj[0] = (d[0] * rect_ux[ref_i] + d[1] * rect_uy[ref_i]) >>> `SAT_PROJ_SHIFT;
            proj[1] = (d[0] * rect_vx[ref_i] + d[1] * rect_vy[ref_i]) >>> `SAT_PROJ_SHIFT;
            for (int k = 0; k < 2; k++) begin
                if (i == 0 || proj[k] < lo[k]) begin
                    lo[k] = proj[k];
                end
                if (i == 0 || proj[k] > hi[k]) begin
                    hi[k] = proj[k];
                end
            end
        end
        sep = 1'b0;
        for (int k = 0; k < 2; k++) begin
            if (lo[k] >= lim[k] || hi[k] <= -lim[k]) begin
                sep = 1'b1;
            end
        end
        return sep;
    endfunction

    task automatic set_rect(input int idx, input int w, input int h, input pos_t px,
                            input pos_t py, input axis_t ux, input axis_t uy,
                            input axis_t vx, input axis_t vy);
        rect_w[idx]  = dim_t'(w);
        rect_h[idx]  = dim_t'(h);
        rect_px[idx] = px;
        rect_py[idx] = py;
        rect_ux[idx] = ux;
        rect_uy[idx] = uy;
        rect_vx[idx] = vx;
        rect_vy[idx] = vy;
    endtask

    task automatic set_aligned(input int idx, input int w, input int h, input pos_t px,
                               input pos_t py);
        set_rect(idx, w, h, px, py, ONE, 0, 0, ONE);
    endtask

    // Sizes and centres stay small enough that no DUT field wraps
    task automatic random_rect(input int idx);
        int   w;
        int   h;
        pos_t px;
        pos_t py;
        w  = $urandom_range(40, 2);
        h  = $urandom_range(40, 2);
        px = pos_t'(int'($urandom_range(2 * POS_SPAN)) - POS_SPAN);
        py = pos_t'(int'($urandom_range(2 * POS_SPAN)) - POS_SPAN);
        if ($urandom_range(1) == 1) begin
            set_aligned(idx, w, h, px, py);
        end else begin
            // Quarter turn, u points along +y
            set_rect(idx, w, h, px, py, 0, ONE, -ONE, 0);
        end
    endtask

    // Strobes the current inputs for one cycle and queues the expected flag
    task automatic issue_query(input string name);
        bit expected;
        expected = !(direction_separates(0, 1) || direction_separates(1, 0));
        exp_q.push_back(expected);
        name_q.push_back(name);
        cur_test = name;
        queries_sent++;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic drain_results();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                $display("Timed out with %0d results still outstanding", exp_q.size());
                $display("Regression failed");
                $fatal(1, "drain timeout");
            end
        end
        // Last result is checked on the following rising edge
        @(negedge clk);
    endtask

    // Expected flag for the result now on the outputs
    always @(negedge clk) begin
        if (!rst && out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("out_valid was raised with no query outstanding");
                $display("Regression failed");
                $fatal(1, "unexpected result");
            end else begin
                exp_head  = exp_q.pop_front();
                head_name = name_q.pop_front();
                results_seen++;
            end
        end
    end

    a_reset_clears: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            $display("FAIL reset expected out_valid 0 actual %0b", $sampled(out_valid));
            $display("Regression failed");
            $fatal(1, "out_valid set after reset");
        end

    // Every strobe comes out three cycles later
    a_latency: assert property (
        @(posedge clk) disable iff (rst) $past(in_valid, 3) |-> out_valid
    ) else begin
        $display("FAIL %s expected out_valid 1 actual %0b", cur_test, $sampled(out_valid));
        $display("Regression failed");
        $fatal(1, "latency mismatch");
    end

    // No result without a strobe three cycles earlier
    a_no_extra_valid: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> $past(in_valid, 3)
    ) else begin
        $display("FAIL %s expected out_valid 0 actual %0b", cur_test, $sampled(out_valid));
        $display("Regression failed");
        $fatal(1, "latency mismatch");
    end

    a_result: assert property (
        @(posedge clk) disable iff (rst) out_valid |-> is_collision == exp_head
    ) else begin
        $display("FAIL %s expected %0b actual %0b", head_name, exp_head,
                 $sampled(is_collision));
        $display("Regression failed");
        $fatal(1, "collision flag mismatch");
    end

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        in_valid     = 1'b0;
        exp_head     = 1'b0;
        head_name    = "none";
        cur_test     = "reset";
        queries_sent = 0;
        results_seen = 0;
        for (int i = 0; i < 2; i++) begin
            set_rect(i, 0, 0, 0, 0, 0, 0, 0, 0);
        end
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        // Idle cycles, out_valid must stay low
        repeat (4) @(negedge clk);

        set_aligned(0, 10, 6, 3 * UNIT, -2 * UNIT);
        set_aligned(1, 10, 6, 3 * UNIT, -2 * UNIT);
        issue_query("overlap_identical");
        drain_results();

        // Three back-to-back queries
        set_aligned(0, 10, 10, 0, 0);
        set_aligned(1, 10, 10, 30 * UNIT, 0);
        issue_query("far_apart_x");
        set_aligned(0, 8, 8, 0, 0);
        set_rect(1, 8, 8, 8 * UNIT, 8 * UNIT, DIAG, DIAG, -DIAG, DIAG);
        issue_query("rotated_b_axis_only");
        set_aligned(0, 8, 6, 0, 0);
        set_aligned(1, 8, 6, 8 * UNIT, 0);
        issue_query("touching_edges");
        drain_results();

        for (int i = 0; i < NUM_RANDOM; i++) begin
            random_rect(0);
            random_rect(1);
            issue_query($sformatf("random_%0d", i));
            if ($urandom_range(3) == 0) begin
                @(negedge clk);
            end
        end
        drain_results();

        if (results_seen == queries_sent) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("Sent %0d queries but saw %0d results", queries_sent, results_seen);
            $display("Regression failed");
            $fatal(1, "result count mismatch");
        end
    end

endmodule

//--- collision_detector.f
+incdir+include
rtl/fxp_pkg.sv
rtl/geom_pkg.sv
rtl/rect_geom_if.sv
rtl/extent_if.sv
rtl/corner_gen.sv
rtl/axis_projector.sv
rtl/sat_decision.sv
rtl/collision_detector.sv
bench/clk_gen.sv
bench/tb_collision_detector.sv

//--- include/sat_macros.svh
`ifndef SAT_MACROS_SVH
`define SAT_MACROS_SVH

// Field widths of the rectangle description
`define SAT_DIM_W        8
`define SAT_HALF_W       7
`define SAT_POS_W        32
`define SAT_AXIS_W       16

// Widths inside the datapath
`define SAT_COORD_W      23
`define SAT_PROD_W       39
`define SAT_PROJ_W       32

// Fixed-point alignment
`define SAT_POS_SHIFT    11
`define SAT_PROJ_SHIFT   3
`define SAT_EXTENT_SHIFT 25

`define SAT_NUM_CORNERS  4

`endif

//--- rtl/axis_projector.sv
`include "sat_macros.svh"

module axis_projector #(
    parameter int unsigned PROJ_SHIFT = `SAT_PROJ_SHIFT
) (
    input  logic          clk,
    input  logic          rst,
    rect_geom_if.own_rect own,
    rect_geom_if.ref_rect ref_geom,
    extent_if.producer    ext
);
    import fxp_pkg::*;

    coord_t ref_x;
    coord_t ref_y;
    proj_t  proj_u [`SAT_NUM_CORNERS];
    proj_t  proj_v [`SAT_NUM_CORNERS];
    proj_t  min_u_nxt;
    proj_t  max_u_nxt;
    proj_t  min_v_nxt;
    proj_t  max_v_nxt;

    // Reference centre in corner units
    assign ref_x = coord_t'(ref_geom.pos_x >>> `SAT_POS_SHIFT);
    assign ref_y = coord_t'(ref_geom.pos_y >>> `SAT_POS_SHIFT);

    // Each corner relative to the reference centre, dotted with both reference axes
    always_comb begin
        coord_t dx;
        coord_t dy;
        prod_t  dot_u;
        prod_t  dot_v;
        for (int i = 0; i < `SAT_NUM_CORNERS; i++) begin
            dx = own.corner_x[i] - ref_x;
            dy = own.corner_y[i] - ref_y;
            dot_u = dx * ref_geom.u_x + dy * ref_geom.u_y;
            dot_v = dx * ref_geom.v_x + dy * ref_geom.v_y;
            proj_u[i] = proj_t'(dot_u >>> PROJ_SHIFT);
            proj_v[i] = proj_t'(dot_v >>> PROJ_SHIFT);
        end
    end

    // Running min and max over all four corners
    always_comb begin
        min_u_nxt = proj_u[0];
        max_u_nxt = proj_u[0];
        min_v_nxt = proj_v[0];
        max_v_nxt = proj_v[0];
        for (int i = 1; i < `SAT_NUM_CORNERS; i++) begin
            if (proj_u[i] < min_u_nxt) begin
                min_u_nxt = proj_u[i];
            end
            if (proj_u[i] > max_u_nxt) begin
                max_u_nxt = proj_u[i];
            end
            if (proj_v[i] < min_v_nxt) begin
                min_v_nxt = proj_v[i];
            end
            if (proj_v[i] > max_v_nxt) begin
                max_v_nxt = proj_v[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ext.valid <= 1'b0;
        end else begin
            ext.valid <= own.valid;
        end
    end

    always_ff @(posedge clk) begin
        ext.min_u      <= min_u_nxt;
        ext.max_u      <= max_u_nxt;
        ext.min_v      <= min_v_nxt;
        ext.max_v      <= max_v_nxt;
        ext.ref_half_w <= ref_geom.half_w;
        ext.ref_half_h <= ref_geom.half_h;
    end

    // Both corner generators run in lockstep on the same query
    a_rects_aligned: assert property (
        @(posedge clk) disable iff (rst) own.valid == ref_geom.valid
    );

endmodule

//--- rtl/collision_detector.sv
module collision_detector (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,

    // Rectangle a
    input  fxp_pkg::dim_t  width_a,
    input  fxp_pkg::dim_t  height_a,
    input  fxp_pkg::pos_t  pos_a_x,
    input  fxp_pkg::pos_t  pos_a_y,
    input  fxp_pkg::axis_t u_a_x,
    input  fxp_pkg::axis_t u_a_y,
    input  fxp_pkg::axis_t v_a_x,
    input  fxp_pkg::axis_t v_a_y,

    // Rectangle b
    input  fxp_pkg::dim_t  width_b,
    input  fxp_pkg::dim_t  height_b,
    input  fxp_pkg::pos_t  pos_b_x,
    input  fxp_pkg::pos_t  pos_b_y,
    input  fxp_pkg::axis_t u_b_x,
    input  fxp_pkg::axis_t u_b_y,
    input  fxp_pkg::axis_t v_b_x,
    input  fxp_pkg::axis_t v_b_y,

    output logic           out_valid,
    output logic           is_collision
);

    rect_geom_if geom_a ();
    rect_geom_if geom_b ();
    extent_if    ext_a_on_b ();
    extent_if    ext_b_on_a ();

    // Stage 1, corners of each rectangle
    corner_gen u_corner_a (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .width    (width_a),
        .height   (height_a),
        .pos_x    (pos_a_x),
        .pos_y    (pos_a_y),
        .u_x      (u_a_x),
        .u_y      (u_a_y),
        .v_x      (v_a_x),
        .v_y      (v_a_y),
        .geom     (geom_a)
    );

    corner_gen u_corner_b (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .width    (width_b),
        .height   (height_b),
        .pos_x    (pos_b_x),
        .pos_y    (pos_b_y),
        .u_x      (u_b_x),
        .u_y      (u_b_y),
        .v_x      (v_b_x),
        .v_y      (v_b_y),
        .geom     (geom_b)
    );

    // Stage 2, each rectangle projected onto the other's axes
    axis_projector u_proj_a_on_b (
        .clk      (clk),
        .rst      (rst),
        .own      (geom_a),
        .ref_geom (geom_b),
        .ext      (ext_a_on_b)
    );

    axis_projector u_proj_b_on_a (
        .clk      (clk),
        .rst      (rst),
        .own      (geom_b),
        .ref_geom (geom_a),
        .ext      (ext_b_on_a)
    );

    // Stage 3
    sat_decision u_decision (
        .clk          (clk),
        .rst          (rst),
        .a_on_b       (ext_a_on_b),
        .b_on_a       (ext_b_on_a),
        .out_valid    (out_valid),
        .is_collision (is_collision)
    );

endmodule

//--- rtl/corner_gen.sv
`include "sat_macros.svh"

module corner_gen (
    input  logic           clk,
    input  logic           rst,
    input  logic           in_valid,
    input  fxp_pkg::dim_t  width,
    input  fxp_pkg::dim_t  height,
    input  fxp_pkg::pos_t  pos_x,
    input  fxp_pkg::pos_t  pos_y,
    input  fxp_pkg::axis_t u_x,
    input  fxp_pkg::axis_t u_y,
    input  fxp_pkg::axis_t v_x,
    input  fxp_pkg::axis_t v_y,
    rect_geom_if.producer  geom
);
    import fxp_pkg::*;
    import geom_pkg::*;

    half_t       half_w;
    half_t       half_h;
    coord_t      centre_x;
    coord_t      centre_y;
    corner_set_t corner_x_nxt;
    corner_set_t corner_y_nxt;

    // Rotated offset of one corner along one world axis
    function automatic coord_t corner_offset(
        input corner_idx_t idx,
        input half_t       hw,
        input half_t       hh,
        input axis_t       a_w,
        input axis_t       a_h
    );
        logic signed [`SAT_HALF_W:0] mult_w;
        logic signed [`SAT_HALF_W:0] mult_h;
        mult_w = $signed({1'b0, hw});
        mult_h = $signed({1'b0, hh});
        if (!idx[1]) begin
            mult_w = -mult_w;
        end
        if (!idx[0]) begin
            mult_h = -mult_h;
        end
        return mult_w * a_w + mult_h * a_h;
    endfunction

    // Dropping the low bit halves the dimension
    assign half_w = width[`SAT_DIM_W-1:1];
    assign half_h = height[`SAT_DIM_W-1:1];

    // Centre brought into corner units
    assign centre_x = coord_t'(pos_x >>> `SAT_POS_SHIFT);
    assign centre_y = coord_t'(pos_y >>> `SAT_POS_SHIFT);

    always_comb begin
        for (int i = 0; i < `SAT_NUM_CORNERS; i++) begin
            corner_x_nxt[i] = corner_offset(corner_idx_t'(i), half_w, half_h, u_x, v_x)
                              + centre_x;
            corner_y_nxt[i] = corner_offset(corner_idx_t'(i), half_w, half_h, u_y, v_y)
                              + centre_y;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            geom.valid <= 1'b0;
        end else begin
            geom.valid <= in_valid;
        end
    end

    // Geometry travels with the corners so the projectors see one query
    always_ff @(posedge clk) begin
        geom.corner_x <= corner_x_nxt;
        geom.corner_y <= corner_y_nxt;
        geom.pos_x    <= pos_x;
        geom.pos_y    <= pos_y;
        geom.u_x      <= u_x;
        geom.u_y      <= u_y;
        geom.v_x      <= v_x;
        geom.v_y      <= v_y;
        geom.half_w   <= half_w;
        geom.half_h   <= half_h;
    end

    // No stale query may leave the first stage after reset
    a_valid_low_after_rst: assert property (@(posedge clk) rst |=> !geom.valid);

endmodule

//--- rtl/extent_if.sv
interface extent_if;
    import fxp_pkg::*;

    logic  valid;

    // Extremes of the projected corners along the reference axes
    proj_t min_u;
    proj_t max_u;
    proj_t min_v;
    proj_t max_v;

    // Half extents of the reference rectangle
    half_t ref_half_w;
    half_t ref_half_h;

    modport producer (
        output valid, min_u, max_u, min_v, max_v, ref_half_w, ref_half_h
    );

    modport consumer (
        input valid, min_u, max_u, min_v, max_v, ref_half_w, ref_half_h
    );

endinterface

//--- rtl/fxp_pkg.sv
`include "sat_macros.svh"

package fxp_pkg;

    // Centre position and unit axis components
    typedef logic signed [`SAT_POS_W-1:0] pos_t;
    typedef logic signed [`SAT_AXIS_W-1:0] axis_t;

    // Corner coordinate after rotation and translation
    typedef logic signed [`SAT_COORD_W-1:0] coord_t;

    // Dot product before and after the fixed-point shift
    typedef logic signed [`SAT_PROD_W-1:0] prod_t;
    typedef logic signed [`SAT_PROJ_W-1:0] proj_t;

    // Sizes in whole units
    typedef logic [`SAT_HALF_W-1:0] half_t;
    typedef logic [`SAT_DIM_W-1:0] dim_t;

endpackage

//--- rtl/geom_pkg.sv
`include "sat_macros.svh"

package geom_pkg;

    // One coordinate of all four corners, element 0 is corner 0
    typedef fxp_pkg::coord_t [`SAT_NUM_CORNERS-1:0] corner_set_t;

    // Bit 1 selects the sign of the width term, bit 0 the height term
    typedef logic [$clog2(`SAT_NUM_CORNERS)-1:0] corner_idx_t;

endpackage

//--- rtl/rect_geom_if.sv
interface rect_geom_if;
    import fxp_pkg::*;
    import geom_pkg::*;

    logic        valid;
    corner_set_t corner_x;
    corner_set_t corner_y;
    pos_t        pos_x;
    pos_t        pos_y;
    axis_t       u_x;
    axis_t       u_y;
    axis_t       v_x;
    axis_t       v_y;
    half_t       half_w;
    half_t       half_h;

    modport producer (
        output valid, corner_x, corner_y, pos_x, pos_y,
        output u_x, u_y, v_x, v_y, half_w, half_h
    );

    // Projector that moves this rectangle's corners
    modport own_rect (input valid, corner_x, corner_y);

    // Projector that uses this rectangle as the reference frame
    modport ref_rect (input valid, pos_x, pos_y, u_x, u_y, v_x, v_y, half_w, half_h);

endinterface

//--- rtl/sat_decision.sv
`include "sat_macros.svh"

module sat_decision (
    input  logic       clk,
    input  logic       rst,
    extent_if.consumer a_on_b,
    extent_if.consumer b_on_a,
    output logic       out_valid,
    output logic       is_collision
);
    import fxp_pkg::*;

    logic sep_a_on_b;
    logic sep_b_on_a;

    // True when either reference axis leaves a gap, touching counts as a gap
    function automatic logic axis_separates(
        input proj_t min_u,
        input proj_t max_u,
        input proj_t min_v,
        input proj_t max_v,
        input half_t hw,
        input half_t hh
    );
        // One extra bit keeps 127 << 25 positive
        logic signed [`SAT_PROJ_W:0] limit_w;
        logic signed [`SAT_PROJ_W:0] limit_h;
        limit_w = $signed({1'b0, hw}) <<< `SAT_EXTENT_SHIFT;
        limit_h = $signed({1'b0, hh}) <<< `SAT_EXTENT_SHIFT;
        return (min_u >= limit_w) || (max_u <= -limit_w)
            || (min_v >= limit_h) || (max_v <= -limit_h);
    endfunction

    assign sep_a_on_b = axis_separates(a_on_b.min_u, a_on_b.max_u, a_on_b.min_v,
                                       a_on_b.max_v, a_on_b.ref_half_w, a_on_b.ref_half_h);
    assign sep_b_on_a = axis_separates(b_on_a.min_u, b_on_a.max_u, b_on_a.min_v,
                                       b_on_a.max_v, b_on_a.ref_half_w, b_on_a.ref_half_h);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= a_on_b.valid;
        end
    end

    // Collision only when no axis of either rectangle separates
    always_ff @(posedge clk) begin
        is_collision <= !(sep_a_on_b || sep_b_on_a);
    end

    a_dirs_aligned: assert property (
        @(posedge clk) disable iff (rst) a_on_b.valid == b_on_a.valid
    );

endmodule

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal --top-module tb_collision_detector \
        -f collision_detector.f -o sim_collision_detector &&
    ./obj_dir/sim_collision_detector || exit 1
